// ==== heapPkg.sv ====
//--------------------------------------------------
// Heap definitions
// Widths, command and error kinds, and the command
// and response structs shared by the heap blocks
//--------------------------------------------------
`default_nettype none

package heapPkg;

  //--------------------------------------------------
  // Geometry
  localparam int ArrayBits   = 2;                   // 4 arrays
  localparam int IndexBits   = 3;                   // 8 elements per array
  localparam int DataBits    = 12;
  localparam int ArrayCount  = 1 << ArrayBits;
  localparam int ArrayLength = 1 << IndexBits;

  typedef logic [ArrayBits-1:0] arrayId_t;
  typedef logic [IndexBits-1:0] index_t;
  typedef logic [IndexBits:0]   size_t;             // Holds 0 to ArrayLength
  typedef logic [DataBits-1:0]  data_t;

  //--------------------------------------------------
  // Command and error kinds
  typedef enum logic [4:0] {
    actClear, actAlloc, actFree, actWrite, actRead, actSize,
    actInc, actDec, actResize, actPush, actPop,
    actAdd, actAddAfter, actSub, actSubAfter,       // Element arithmetic
    actShiftLeft, actShiftRight,
    actNotLogical, actNot, actOr, actXor, actAnd    // Element logic
  } heapAction_t;

  typedef enum logic [2:0] {
    errNone,
    errUnallocated,                                 // Never handed out
    errFreed,
    errBounds,
    errFull,
    errEmpty,
    errNoMemory                                     // No array left for alloc
  } heapError_t;

  //--------------------------------------------------
  // Command and response
  typedef struct packed {
    heapAction_t action;
    arrayId_t    array;
    index_t      index;
    data_t       data;
  } heapCmd_t;

  typedef struct packed {
    data_t      data;
    heapError_t error;
  } heapResp_t;

endpackage

`default_nettype wire

// ==== heapAllocator.sv ====
//--------------------------------------------------
// Heap allocator
// Tracks live arrays, hands out fresh or recently
// freed arrays and reports liveness of each command
//--------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module heapAllocator (
  input  wire                 clock,
  input  wire                 resetN,
  input  wire                 cmdValid,
  input  heapPkg::heapCmd_t   cmd,
  output heapPkg::heapError_t access,
  output heapPkg::heapResp_t  allocResp,
  output logic                claimValid,
  output heapPkg::arrayId_t   claimArray
);

  logic [heapPkg::ArrayCount-1:0] flags;            // One bit per live array
  logic [heapPkg::ArrayBits:0]    freshCount;       // Next never used array
  logic [heapPkg::ArrayBits:0]    stackTop;         // Entries in freed stack
  heapPkg::arrayId_t              freedStack [heapPkg::ArrayCount];
  heapPkg::arrayId_t              topSlot;
  heapPkg::arrayId_t              allocId;
  logic                           fromStack;
  logic                           allocOk;

  assign topSlot   = stackTop[heapPkg::ArrayBits-1:0] - 1'b1;
  assign fromStack = stackTop != '0;

  // Liveness of the addressed array
  always_comb begin
    access = heapPkg::errNone;
    if ({1'b0, cmd.array} >= freshCount) begin
      access = heapPkg::errUnallocated;
    end else if (!flags[cmd.array]) begin
      access = heapPkg::errFreed;
    end
  end

  // Reuse last freed first, else take a fresh one
  always_comb begin
    allocId = freshCount[heapPkg::ArrayBits-1:0];
    allocOk = freshCount < heapPkg::ArrayCount;
    if (fromStack) begin
      allocId = freedStack[topSlot];
      allocOk = 1'b1;
    end
  end

  //--------------------------------------------------
  // Allocation state
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      flags      <= '0;
      freshCount <= '0;
      stackTop   <= '0;
      claimValid <= 1'b0;
      allocResp  <= '0;
    end else begin
      claimValid <= 1'b0;
      if (cmdValid) begin
        case (cmd.action)
          heapPkg::actClear: begin
            flags      <= '0;
            freshCount <= '0;
            stackTop   <= '0;
            allocResp  <= '{data: '0, error: heapPkg::errNone};
          end
          heapPkg::actAlloc: begin
            if (fromStack) begin
              stackTop <= stackTop - 1'b1;
            end else if (allocOk) begin
              freshCount <= freshCount + 1'b1;
            end
            if (allocOk) begin
              flags[allocId] <= 1'b1;
              claimValid     <= 1'b1;                // Store zeroes the size
              allocResp      <= '{data: heapPkg::data_t'(allocId), error: heapPkg::errNone};
            end else begin
              allocResp <= '{data: '0, error: heapPkg::errNoMemory};
            end
          end
          heapPkg::actFree: begin
            allocResp <= '{data: '0, error: access};
            if (access == heapPkg::errNone) begin
              flags[cmd.array] <= 1'b0;
              stackTop         <= stackTop + 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Freed stack and claim target
  always_ff @(posedge clock) begin
    if (cmdValid && cmd.action == heapPkg::actFree && access == heapPkg::errNone) begin
      freedStack[stackTop[heapPkg::ArrayBits-1:0]] <= cmd.array;
    end
    if (cmdValid && cmd.action == heapPkg::actAlloc) begin
      claimArray <= allocId;
    end
  end

endmodule

`default_nettype wire

// ==== heapAlu.sv ====
//--------------------------------------------------
// Heap element ALU
// Arithmetic and logic on one element for the
// modify actions
//--------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module heapAlu (
  input  heapPkg::heapAction_t action,
  input  heapPkg::data_t       element,
  input  heapPkg::data_t       operand,
  output heapPkg::data_t       newValue,
  output heapPkg::data_t       respValue
);

  always_comb begin
    newValue = element;                             // Unchanged for other actions
    case (action)
      heapPkg::actAdd,
      heapPkg::actAddAfter:   newValue = element + operand;
      heapPkg::actSub,
      heapPkg::actSubAfter:   newValue = element - operand;
      heapPkg::actShiftLeft:  newValue = element << operand;
      heapPkg::actShiftRight: newValue = element >> operand;
      heapPkg::actNotLogical: newValue = (element == '0) ? heapPkg::data_t'(1) : '0;
      heapPkg::actNot:        newValue = ~element;
      heapPkg::actOr:         newValue = element | operand;
      heapPkg::actXor:        newValue = element ^ operand;
      heapPkg::actAnd:        newValue = element & operand;
      default: ;
    endcase
  end

  // After forms answer with the old value
  always_comb begin
    if (action == heapPkg::actAddAfter || action == heapPkg::actSubAfter) begin
      respValue = element;
    end else begin
      respValue = newValue;
    end
  end

endmodule

`default_nettype wire

// ==== heapStore.sv ====
//--------------------------------------------------
// Heap store
// Element memory and array sizes, capacity and
// bounds checks, and the registered response
//--------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module heapStore (
  input  wire                 clock,
  input  wire                 resetN,
  input  wire                 cmdValid,
  input  heapPkg::heapCmd_t   cmd,
  input  heapPkg::heapError_t access,
  input  heapPkg::heapResp_t  allocResp,
  input  wire                 claimValid,
  input  heapPkg::arrayId_t   claimArray,
  output logic                respValid,
  output heapPkg::heapResp_t  resp
);

  heapPkg::data_t     memory [heapPkg::ArrayCount][heapPkg::ArrayLength];
  heapPkg::size_t     sizes  [heapPkg::ArrayCount];
  heapPkg::size_t     curSize;
  heapPkg::size_t     newSize;
  heapPkg::index_t    readIndex;
  heapPkg::index_t    writeIndex;
  heapPkg::data_t     element;
  heapPkg::data_t     writeData;
  heapPkg::data_t     aluNew;
  heapPkg::data_t     aluResp;
  heapPkg::heapResp_t nextResp;
  heapPkg::heapResp_t storeResp;
  logic               writeEn;
  logic               sizeEn;
  logic               passAlloc;                    // Answer comes from allocator

  // A claim in flight reads as an empty array
  assign curSize   = (claimValid && claimArray == cmd.array) ? '0 : sizes[cmd.array];
  assign readIndex = (cmd.action == heapPkg::actPop) ?
                     heapPkg::index_t'(curSize - 1'b1) : cmd.index;
  assign element   = memory[cmd.array][readIndex];

  heapAlu alu0 (
    .action    (cmd.action),
    .element   (element),
    .operand   (cmd.data),
    .newValue  (aluNew),
    .respValue (aluResp)
  );

  //--------------------------------------------------
  // Command decode and checks
  always_comb begin
    nextResp   = '{data: '0, error: access};
    writeEn    = 1'b0;
    writeIndex = cmd.index;
    writeData  = cmd.data;
    sizeEn     = 1'b0;
    newSize    = curSize;
    if (access == heapPkg::errNone) begin
      case (cmd.action)
        heapPkg::actWrite: begin
          writeEn       = 1'b1;
          nextResp.data = cmd.data;
          if ({1'b0, cmd.index} >= curSize) begin
            sizeEn  = 1'b1;
            newSize = heapPkg::size_t'(cmd.index) + 1'b1;
          end
        end
        heapPkg::actRead: begin
          if ({1'b0, cmd.index} >= curSize) nextResp.error = heapPkg::errBounds;
          else nextResp.data = element;
        end
        heapPkg::actSize: nextResp.data = heapPkg::data_t'(curSize);
        heapPkg::actInc, heapPkg::actPush: begin
          if (curSize == heapPkg::ArrayLength) begin
            nextResp.error = heapPkg::errFull;
          end else begin
            sizeEn        = 1'b1;
            newSize       = curSize + 1'b1;
            nextResp.data = heapPkg::data_t'(newSize);
            writeEn       = cmd.action == heapPkg::actPush;
            writeIndex    = heapPkg::index_t'(curSize);  // Slot after the top
          end
        end
        heapPkg::actDec, heapPkg::actPop: begin
          if (curSize == '0) begin
            nextResp.error = heapPkg::errEmpty;
          end else begin
            sizeEn        = 1'b1;
            newSize       = curSize - 1'b1;
            nextResp.data = (cmd.action == heapPkg::actPop) ? element :
                            heapPkg::data_t'(newSize);
          end
        end
        heapPkg::actResize: begin
          if (cmd.data > heapPkg::ArrayLength) begin
            nextResp.error = heapPkg::errFull;
          end else begin
            sizeEn        = 1'b1;
            newSize       = heapPkg::size_t'(cmd.data);
            nextResp.data = heapPkg::data_t'(newSize);
          end
        end
        heapPkg::actAdd, heapPkg::actAddAfter, heapPkg::actSub, heapPkg::actSubAfter,
        heapPkg::actShiftLeft, heapPkg::actShiftRight, heapPkg::actNotLogical,
        heapPkg::actNot, heapPkg::actOr, heapPkg::actXor, heapPkg::actAnd: begin
          if ({1'b0, cmd.index} >= curSize) begin
            nextResp.error = heapPkg::errBounds;
          end else begin
            writeEn       = 1'b1;
            writeData     = aluNew;
            nextResp.data = aluResp;
          end
        end
        default: ;                                  // Clear, alloc and free
      endcase
    end
  end

  //--------------------------------------------------
  // State and response registers
  always_ff @(posedge clock) begin
    if (cmdValid && writeEn) begin
      memory[cmd.array][writeIndex] <= writeData;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < heapPkg::ArrayCount; i++) begin
        sizes[i] <= '0;
      end
      respValid <= 1'b0;
      passAlloc <= 1'b0;
      storeResp <= '0;
    end else begin
      if (claimValid) sizes[claimArray] <= '0;      // Claim first, command may override
      if (cmdValid && sizeEn) sizes[cmd.array] <= newSize;
      respValid <= cmdValid;
      passAlloc <= cmd.action inside {heapPkg::actClear, heapPkg::actAlloc, heapPkg::actFree};
      storeResp <= nextResp;
    end
  end

  assign resp = passAlloc ? allocResp : storeResp;

endmodule

`default_nettype wire

// ==== heapTop.sv ====
//--------------------------------------------------
// Heap top
// Array heap answering each command one cycle later
//--------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module heapTop (
  input  wire                clock,
  input  wire                resetN,
  input  wire                cmdValid,
  input  heapPkg::heapCmd_t  cmd,
  output logic               respValid,
  output heapPkg::heapResp_t resp
);

  heapPkg::heapError_t access;                      // Liveness of cmd.array
  heapPkg::heapResp_t  allocResp;
  logic                claimValid;
  heapPkg::arrayId_t   claimArray;

  heapAllocator allocator0 (
    .clock      (clock),
    .resetN     (resetN),
    .cmdValid   (cmdValid),
    .cmd        (cmd),
    .access     (access),
    .allocResp  (allocResp),
    .claimValid (claimValid),
    .claimArray (claimArray)
  );

  heapStore store0 (
    .clock      (clock),
    .resetN     (resetN),
    .cmdValid   (cmdValid),
    .cmd        (cmd),
    .access     (access),
    .allocResp  (allocResp),
    .claimValid (claimValid),
    .claimArray (claimArray),
    .respValid  (respValid),
    .resp       (resp)
  );

endmodule

`default_nettype wire

// ==== heapTop_asserts.sv ====
//--------------------------------------------------
// Heap timing assertions
// Response strobe timing and reset state of heapTop
//--------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module heapTopAsserts (
  input wire clock,
  input wire resetN,
  input wire cmdValid,
  input wire respValid,
  input wire claimValid
);

  int assertFailures = 0;                           // Failed assertion count

  respAfterCmd: assert property (@(posedge clock) disable iff (!resetN)
    cmdValid |=> respValid)
    else begin
      assertFailures++;
      $error("respValid did not follow a command after one cycle");
    end

  noRespWithoutCmd: assert property (@(posedge clock) disable iff (!resetN)
    !cmdValid |=> !respValid)
    else begin
      assertFailures++;
      $error("respValid was high without a command in the cycle before");
    end

  quietInReset: assert property (@(posedge clock)
    !resetN |-> (!respValid && !claimValid))
    else begin
      assertFailures++;
      $error("respValid or claimValid was high during reset");
    end

endmodule

bind heapTop heapTopAsserts asserts0 (
  .clock      (clock),
  .resetN     (resetN),
  .cmdValid   (cmdValid),
  .respValid  (respValid),
  .claimValid (claimValid)
);

`default_nettype wire

// ==== heapTb.sv ====
//--------------------------------------------------
// Heap testbench
// Random commands checked against a reference model
//--------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module heapTb;

  localparam int NumCommands   = 2000;
  localparam int ResetCycles   = 10;
  localparam int PreambleCount = heapPkg::ArrayCount * (heapPkg::ArrayLength + 1) + 1;
  localparam int IdleBudget    = 64;                // Most idle cycles inserted
  localparam int CycleLimit    = ResetCycles + PreambleCount + NumCommands + IdleBudget + 100;

  logic               clock;
  logic               resetN;
  logic               cmdValid;
  heapPkg::heapCmd_t  cmd;
  logic               respValid;
  heapPkg::heapResp_t resp;

  //--------------------------------------------------
  // Reference model state
  logic [heapPkg::ArrayCount-1:0] modelFlags;
  int                             modelFresh;
  heapPkg::arrayId_t              modelStack [$];   // Last freed at the back
  int                             modelSize  [heapPkg::ArrayCount];
  heapPkg::data_t                 modelMem   [heapPkg::ArrayCount][heapPkg::ArrayLength];

  logic               expectValid;
  heapPkg::heapResp_t expectResp;
  int                 followId;                     // Array from the last alloc
  int                 checkCount;
  int                 errorCount;
  int                 timeoutCount;
  int                 cycleCount;
  int                 idleUsed;

  heapTop dut0 (
    .clock     (clock),
    .resetN    (resetN),
    .cmdValid  (cmdValid),
    .cmd       (cmd),
    .respValid (respValid),
    .resp      (resp)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Load, store, size and modify actions on a live array
  task automatic modelElement(input heapPkg::heapCmd_t c, inout heapPkg::heapResp_t r);
    heapPkg::data_t oldValue;
    heapPkg::data_t newValue;
    int             a;
    int             i;
    a = c.array;
    i = c.index;
    case (c.action)
      heapPkg::actWrite: begin
        modelMem[a][i] = c.data;
        if (i >= modelSize[a]) modelSize[a] = i + 1;
        r.data = c.data;
      end
      heapPkg::actRead: begin
        if (i >= modelSize[a]) r.error = heapPkg::errBounds;
        else r.data = modelMem[a][i];
      end
      heapPkg::actSize: r.data = heapPkg::data_t'(modelSize[a]);
      heapPkg::actInc, heapPkg::actPush: begin
        if (modelSize[a] == heapPkg::ArrayLength) begin
          r.error = heapPkg::errFull;
        end else begin
          if (c.action == heapPkg::actPush) modelMem[a][modelSize[a]] = c.data;
          modelSize[a]++;
          r.data = heapPkg::data_t'(modelSize[a]);
        end
      end
      heapPkg::actDec, heapPkg::actPop: begin
        if (modelSize[a] == 0) begin
          r.error = heapPkg::errEmpty;
        end else begin
          modelSize[a]--;
          if (c.action == heapPkg::actPop) r.data = modelMem[a][modelSize[a]];
          else r.data = heapPkg::data_t'(modelSize[a]);
        end
      end
      heapPkg::actResize: begin
        if (c.data > heapPkg::ArrayLength) begin
          r.error = heapPkg::errFull;
        end else begin
          modelSize[a] = c.data;
          r.data = c.data;
        end
      end
      default: begin                                // Modify actions
        if (i >= modelSize[a]) begin
          r.error = heapPkg::errBounds;
        end else begin
          oldValue = modelMem[a][i];
          case (c.action)
            heapPkg::actAdd, heapPkg::actAddAfter: newValue = oldValue + c.data;
            heapPkg::actSub, heapPkg::actSubAfter: newValue = oldValue - c.data;
            heapPkg::actShiftLeft:  newValue = oldValue << c.data;
            heapPkg::actShiftRight: newValue = oldValue >> c.data;
            heapPkg::actNotLogical: newValue = (oldValue == 0) ? 12'd1 : 12'd0;
            heapPkg::actNot:        newValue = ~oldValue;
            heapPkg::actOr:         newValue = oldValue | c.data;
            heapPkg::actXor:        newValue = oldValue ^ c.data;
            default:                newValue = oldValue & c.data;
          endcase
          modelMem[a][i] = newValue;
          if (c.action inside {heapPkg::actAddAfter, heapPkg::actSubAfter}) r.data = oldValue;
          else r.data = newValue;
        end
      end
    endcase
  endtask

  task automatic applyModel(input heapPkg::heapCmd_t c, output heapPkg::heapResp_t r);
    heapPkg::heapError_t live;
    int                  id;
    r = '{data: '0, error: heapPkg::errNone};
    if (c.array >= modelFresh) live = heapPkg::errUnallocated;
    else if (!modelFlags[c.array]) live = heapPkg::errFreed;
    else live = heapPkg::errNone;
    case (c.action)
      heapPkg::actClear: begin
        modelFlags = '0;
        modelFresh = 0;
        modelStack.delete();
      end
      heapPkg::actAlloc: begin
        id = -1;
        if (modelStack.size() > 0) begin
          id = modelStack.pop_back();
        end else if (modelFresh < heapPkg::ArrayCount) begin
          id = modelFresh;
          modelFresh++;
        end
        if (id < 0) begin
          r.error = heapPkg::errNoMemory;
        end else begin
          modelFlags[id] = 1'b1;
          modelSize[id]  = 0;                       // New array starts empty
          r.data         = heapPkg::data_t'(id);
        end
      end
      heapPkg::actFree: begin
        r.error = live;
        if (live == heapPkg::errNone) begin
          modelFlags[c.array] = 1'b0;
          modelStack.push_back(c.array);
        end
      end
      default: begin
        if (live != heapPkg::errNone) r.error = live;
        else modelElement(c, r);
      end
    endcase
  endtask

  //--------------------------------------------------
  // Stimulus
  function automatic heapPkg::heapAction_t pickAction(input int n);
    int r;
    r = $urandom_range(0, 99);
    if (n < 200) begin                              // Fill the heap early on
      if (r < 35) return heapPkg::actAlloc;
      if (r < 45) return heapPkg::actFree;
      if (r < 70) return heapPkg::actWrite;
    end else begin
      if (r < 1)  return heapPkg::actClear;
      if (r < 8)  return heapPkg::actAlloc;
      if (r < 14) return heapPkg::actFree;
      if (r < 26) return heapPkg::actWrite;
      if (r < 34) return heapPkg::actRead;
      if (r < 38) return heapPkg::actSize;
      if (r < 42) return heapPkg::actInc;
      if (r < 46) return heapPkg::actDec;
      if (r < 50) return heapPkg::actResize;
      if (r < 56) return heapPkg::actPush;
      if (r < 62) return heapPkg::actPop;
    end
    return heapPkg::heapAction_t'(int'(heapPkg::actAdd) + $urandom_range(0, 10));
  endfunction

  task automatic makeCommand(input int n, output heapPkg::heapCmd_t c);
    c.action = pickAction(n);
    c.array  = heapPkg::arrayId_t'($urandom_range(0, heapPkg::ArrayCount - 1));
    c.index  = heapPkg::index_t'($urandom_range(0, heapPkg::ArrayLength - 1));
    c.data   = heapPkg::data_t'($urandom);
    if (followId >= 0 && $urandom_range(0, 1) == 1) begin
      c.array = heapPkg::arrayId_t'(followId);      // Hit the claim in flight
      case ($urandom_range(0, 3))
        0:       c.action = heapPkg::actWrite;
        1:       c.action = heapPkg::actPush;
        2:       c.action = heapPkg::actInc;
        default: c.action = heapPkg::actSize;
      endcase
    end
    if (c.action == heapPkg::actResize) begin
      c.data = heapPkg::data_t'($urandom_range(0, heapPkg::ArrayLength + 1));
    end
    if (c.action inside {heapPkg::actShiftLeft, heapPkg::actShiftRight}) begin
      c.data = heapPkg::data_t'($urandom_range(0, heapPkg::DataBits + 1));
    end
  endtask

  // Outputs registered at the last rising edge, read at the falling edge
  task automatic checkResponse();
    assert (respValid === expectValid) else begin
      errorCount++;
      $display("** Error at %0t: respValid expected %b, got %b", $time, expectValid, respValid);
    end
    if (expectValid) begin
      checkCount++;
      assert (resp.data === expectResp.data) else begin
        errorCount++;
        $display("** Error at %0t: resp.data expected %h, got %h",
                 $time, expectResp.data, resp.data);
      end
      assert (resp.error === expectResp.error) else begin
        errorCount++;
        $display("** Error at %0t: resp.error expected %s, got %s",
                 $time, expectResp.error.name(), resp.error.name());
      end
    end
  endtask

  task automatic driveCycle(input logic valid, input heapPkg::heapCmd_t c);
    heapPkg::heapResp_t r;
    @(negedge clock);
    checkResponse();
    cmdValid    = valid;
    cmd         = c;
    expectValid = valid;
    followId    = -1;
    if (valid) begin
      applyModel(c, r);
      expectResp = r;
      if (c.action == heapPkg::actAlloc && r.error == heapPkg::errNone) followId = r.data;
    end
  endtask

  task automatic reportAndFinish();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
             checkCount, errorCount, dut0.asserts0.assertFailures, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0 && dut0.asserts0.assertFailures == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  //--------------------------------------------------
  // Main sequence
  initial begin
    heapPkg::heapCmd_t c;
    void'($urandom(32'hce1e));
    resetN       = 1'b0;
    cmdValid     = 1'b0;
    cmd          = '0;
    expectValid  = 1'b0;
    expectResp   = '0;
    followId     = -1;
    checkCount   = 0;
    errorCount   = 0;
    timeoutCount = 0;
    idleUsed     = 0;
    modelFlags   = '0;
    modelFresh   = 0;
    for (int a = 0; a < heapPkg::ArrayCount; a++) modelSize[a] = 0;
    repeat (ResetCycles) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;
    // Claim every array and fill all elements so later reads are known
    for (int a = 0; a < heapPkg::ArrayCount; a++) begin
      c = '{action: heapPkg::actAlloc, array: '0, index: '0, data: '0};
      driveCycle(1'b1, c);
    end
    for (int a = 0; a < heapPkg::ArrayCount; a++) begin
      for (int i = 0; i < heapPkg::ArrayLength; i++) begin
        c = '{action: heapPkg::actWrite, array: heapPkg::arrayId_t'(a),
              index: heapPkg::index_t'(i), data: heapPkg::data_t'($urandom)};
        driveCycle(1'b1, c);
      end
    end
    c.action = heapPkg::actClear;
    driveCycle(1'b1, c);
    for (int n = 0; n < NumCommands; n++) begin
      if (idleUsed < IdleBudget && $urandom_range(0, 31) == 0) begin
        idleUsed++;
        driveCycle(1'b0, c);
      end
      makeCommand(n, c);
      driveCycle(1'b1, c);
    end
    driveCycle(1'b0, c);                            // Collect the last response
    reportAndFinish();
  end

  // Cycle limit
  initial begin
    cycleCount = 0;
    while (cycleCount < CycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Run stopped: the cycle limit of %0d was reached before all commands ran",
             CycleLimit);
    timeoutCount++;
    reportAndFinish();
  end

endmodule

`default_nettype wire

// ==== files.f ====
heapPkg.sv
heapAllocator.sv
heapAlu.sv
heapStore.sv
heapTop.sv
heapTop_asserts.sv
heapTb.sv

// ==== Bender.yml ====
package:
  name: heap

sources:
  - heapPkg.sv
  - heapAllocator.sv
  - heapAlu.sv
  - heapStore.sv
  - heapTop.sv
  - target: simulation
    files:
      - heapTop_asserts.sv
      - heapTb.sv
